// ==== logic/edm_settings.svh ====
`ifndef EDM_SETTINGS_SVH
`define EDM_SETTINGS_SVH

// widths
`define EDM_SAMPLE_W 16 // adc samples, waveform code, us inputs
`define EDM_TIMER_W 32 // state timer and tick counts

// clock and gate timing
`define EDM_TICKS_PER_US 100 // 10 ns clock
`define EDM_DEAD_TIME 10 // ticks between upper and lower device
`define EDM_BUCK_PERIOD 400 // one buck period, 4 us
`define EDM_BUCK_HALF 200 // 180 deg leg offset

// limits
`define EDM_WAIT_MAX 10000 // breakdown wait timeout, ticks
`define EDM_MAX_CURRENT 76 // on total current, twice the sample

// breakdown qualify
`define EDM_BD_VOLTAGE 40 // gap voltage must fall below this
`define EDM_BD_CURRENT 10 // and current must exceed this
`define EDM_BD_TICKS 10 // for this many ticks in a row

// open-loop charge profile
`define EDM_CHARGE_RISE 120 // charge ticks while current builds up
`define EDM_CHARGE_STAND 80 // charge ticks once it stands
`define EDM_RISE_CYCLES 3 // periods at the rise charge time

`endif

// ==== logic/edm_state_pkg.sv ====
package edm_state_pkg;

	// discharge cycle states
	typedef enum logic [2:0]
	{
		S_DEION = 3'd0, // toff, deion switch on
		S_WAIT_BREAKDOWN = 3'd1, // gap under open-circuit voltage
		S_BUCK_INTERLEAVE = 3'd2, // ton via the two buck legs
		S_RES_DISCHARGE = 3'd3 // ton via the resistor leg
	} seq_state_e;

	// half-bridge code, bit 1 upper device, bit 0 lower device
	// 2'b11 would short the bridge and is never used
	typedef enum logic [1:0]
	{
		GATE_OFF = 2'b00,
		GATE_LOW = 2'b01, // lower on
		GATE_HIGH = 2'b10 // upper on
	} gate_e;

endpackage

// ==== logic/edm_wave_pkg.sv ====
package edm_wave_pkg;

	// accepted waveform codes
	typedef enum logic [15:0]
	{
		WAVE_BUCK_OPEN = 16'h0001, // continuous open-loop buck, rectangle
		WAVE_RES = 16'h8000 // resistor discharge
	} wave_e;

	// what the discharge phase will run
	typedef enum logic [1:0]
	{
		DIS_NONE = 2'd0, // unknown code, wait times out
		DIS_BUCK = 2'd1,
		DIS_RES = 2'd2
	} discharge_e;

endpackage

// ==== logic/pulse_sequencer.sv ====
`timescale 1ns/1ps
`include "edm_settings.svh"

module pulse_sequencer
	import edm_state_pkg::*, edm_wave_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic machine_on,
	input logic [`EDM_SAMPLE_W-1:0] waveform,
	input logic [`EDM_SAMPLE_W-1:0] ton_us,
	input logic [`EDM_SAMPLE_W-1:0] toff_us,
	input logic signed [`EDM_SAMPLE_W-1:0] sample_current,
	input logic is_breakdown,
	output seq_state_e state,
	output logic [`EDM_TIMER_W-1:0] state_timer,
	output logic [`EDM_TIMER_W-1:0] toff_ticks,
	output logic buck_active,
	output logic wait_active,
	output logic is_operation
);

	logic signed [`EDM_SAMPLE_W:0] total_current; // one extra bit for the doubling
	logic overcurrent;
	logic [`EDM_TIMER_W-1:0] ton_ticks;
	discharge_e dis_kind;
	seq_state_e next_state;

	// sample covers one leg, both legs carry the same
	assign total_current = $signed({sample_current, 1'b0});

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			overcurrent <= 1'b0;
			is_operation <= 1'b0;
		end
		else
		begin
			overcurrent <= (total_current > `EDM_MAX_CURRENT);
			is_operation <= machine_on && !overcurrent; // second stage, 2 cycles total
		end
	end

	// us to clock ticks
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ton_ticks <= '0;
			toff_ticks <= '0;
		end
		else
		begin
			ton_ticks <= `EDM_TIMER_W'(ton_us) * `EDM_TICKS_PER_US;
			toff_ticks <= `EDM_TIMER_W'(toff_us) * `EDM_TICKS_PER_US;
		end
	end

	always_comb
	begin
		case (wave_e'(waveform))
			WAVE_BUCK_OPEN: dis_kind = DIS_BUCK;
			WAVE_RES: dis_kind = DIS_RES;
			default: dis_kind = DIS_NONE; // never discharges, times out
		endcase
	end

	always_comb
	begin
		next_state = state; // stay by default
		case (state)
			S_DEION:
				if (state_timer >= toff_ticks && is_operation)
					next_state = S_WAIT_BREAKDOWN;
			S_WAIT_BREAKDOWN:
			begin
				if (is_breakdown && is_operation && state_timer <= `EDM_WAIT_MAX
					&& dis_kind == DIS_BUCK)
					next_state = S_BUCK_INTERLEAVE;
				else if (is_breakdown && is_operation && state_timer <= `EDM_WAIT_MAX
					&& dis_kind == DIS_RES)
					next_state = S_RES_DISCHARGE;
				else if (state_timer > `EDM_WAIT_MAX || !is_operation)
					next_state = S_DEION; // timeout or machine stopped
			end
			S_BUCK_INTERLEAVE:
				if (state_timer >= ton_ticks)
					next_state = S_DEION; // buck runs its full ton
			S_RES_DISCHARGE:
				if (state_timer >= ton_ticks || !is_operation)
					next_state = S_DEION;
			default:
				next_state = S_DEION;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= S_DEION;
		else
			state <= next_state;
	end

	// single timer shared by all states
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_timer <= '0;
		else if (next_state != state)
			state_timer <= '0; // 0 on the first tick of the new state
		else
			state_timer <= state_timer + 1'b1;
	end

	assign buck_active = (state == S_BUCK_INTERLEAVE);
	assign wait_active = (state == S_WAIT_BREAKDOWN);

	// a discharge only ever follows a detected breakdown
	deion_never_skips_wait: assert property (@(posedge clk) disable iff (!rst_n)
		state == S_DEION |=> state inside {S_DEION, S_WAIT_BREAKDOWN});

endmodule

// ==== logic/breakdown_detector.sv ====
`timescale 1ns/1ps
`include "edm_settings.svh"

module breakdown_detector
(
	input logic clk,
	input logic rst_n,
	input logic wait_active,
	input logic signed [`EDM_SAMPLE_W-1:0] sample_voltage,
	input logic signed [`EDM_SAMPLE_W-1:0] sample_current,
	output logic is_breakdown
);

	localparam int QUAL_W = $clog2(`EDM_BD_TICKS + 1);

	logic [QUAL_W-1:0] qual_cnt; // consecutive qualifying ticks
	logic sample_ok;

	// gap collapsed and current flowing
	assign sample_ok = wait_active
		&& (sample_voltage < `EDM_BD_VOLTAGE)
		&& (sample_current > `EDM_BD_CURRENT);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			qual_cnt <= '0;
		else if (!sample_ok)
			qual_cnt <= '0; // any miss restarts the count
		else if (qual_cnt != QUAL_W'(`EDM_BD_TICKS))
			qual_cnt <= qual_cnt + 1'b1;
		// else saturate
	end

	// held while the counter sits at the top
	assign is_breakdown = (qual_cnt == QUAL_W'(`EDM_BD_TICKS));

endmodule

// ==== logic/buck_phase_timer.sv ====
`timescale 1ns/1ps
`include "edm_settings.svh"

module buck_phase_timer
	import edm_state_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic buck_active,
	output gate_e buck1_code,
	output gate_e buck2_code
);

	localparam int PHASE_W = $clog2(`EDM_BUCK_PERIOD + 1); // holds the idle value too
	localparam int CYCLE_W = 16;

	logic [PHASE_W-1:0] phase0; // 0 deg leg
	logic [PHASE_W-1:0] phase180; // 180 deg leg, idle at period
	logic [CYCLE_W-1:0] cycle_num; // completed periods, saturating
	logic [PHASE_W-1:0] charge0;
	logic [PHASE_W-1:0] charge180;
	logic phase180_idle;

	// off, charge (upper), off, freewheel (lower)
	function automatic gate_e leg_code(input logic [PHASE_W-1:0] c, input logic [PHASE_W-1:0] t);
		if (c < `EDM_DEAD_TIME)
			return GATE_OFF; // lower device turning off
		else if (c < t + `EDM_DEAD_TIME)
			return GATE_HIGH;
		else if (c < t + 2 * `EDM_DEAD_TIME)
			return GATE_OFF; // upper device turning off
		return GATE_LOW;
	endfunction

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase0 <= '0;
			phase180 <= PHASE_W'(`EDM_BUCK_PERIOD);
			cycle_num <= '0;
			charge180 <= '0;
		end
		else if (!buck_active)
		begin
			phase0 <= '0;
			phase180 <= PHASE_W'(`EDM_BUCK_PERIOD); // idle, past any charge window
			cycle_num <= '0;
		end
		else
		begin
			if (phase0 == PHASE_W'(`EDM_BUCK_PERIOD - 1))
				phase0 <= '0;
			else
				phase0 <= phase0 + 1'b1;
			if (phase0 == PHASE_W'(`EDM_BUCK_PERIOD - 1) && cycle_num != '1)
				cycle_num <= cycle_num + 1'b1;
			if (phase0 == PHASE_W'(`EDM_BUCK_HALF - 1))
			begin
				phase180 <= '0; // half period behind leg 1
				charge180 <= charge0; // constant within the period
			end
			else if (phase180 < PHASE_W'(`EDM_BUCK_PERIOD))
				phase180 <= phase180 + 1'b1;
		end
	end

	// open-loop profile, longer charge while current rises
	assign charge0 = (cycle_num < `EDM_RISE_CYCLES) ? PHASE_W'(`EDM_CHARGE_RISE)
		: PHASE_W'(`EDM_CHARGE_STAND);
	assign phase180_idle = (phase180 == PHASE_W'(`EDM_BUCK_PERIOD));

	assign buck1_code = leg_code(phase0, charge0);

	always_comb
	begin
		if (phase180_idle)
			buck2_code = GATE_OFF;
		else
		begin
			buck2_code = leg_code(phase180, charge180);
			if (buck2_code == GATE_LOW && cycle_num == '0)
				buck2_code = GATE_OFF; // no freewheel before the first full period
		end
	end

endmodule

// ==== logic/mosfet_driver.sv ====
`timescale 1ns/1ps
`include "edm_settings.svh"

module mosfet_driver
	import edm_state_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input seq_state_e state,
	input logic [`EDM_TIMER_W-1:0] state_timer,
	input logic [`EDM_TIMER_W-1:0] toff_ticks,
	input gate_e buck1_code,
	input gate_e buck2_code,
	output gate_e mosfet_buck1,
	output gate_e mosfet_buck2,
	output gate_e mosfet_res1,
	output gate_e mosfet_res2,
	output logic mosfet_deion
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mosfet_buck1 <= GATE_OFF;
			mosfet_buck2 <= GATE_OFF;
			mosfet_res1 <= GATE_OFF;
			mosfet_res2 <= GATE_OFF;
			mosfet_deion <= 1'b0;
		end
		else
		begin
			case (state)
				S_DEION:
				begin
					if (state_timer < `EDM_DEAD_TIME)
					begin
						// legs arrive in any code, only an upper device needs a gap
						if (mosfet_buck1 == GATE_HIGH)
							mosfet_buck1 <= GATE_OFF;
						if (mosfet_buck2 == GATE_HIGH)
							mosfet_buck2 <= GATE_OFF;
						mosfet_res1 <= GATE_LOW;
						mosfet_res2 <= GATE_LOW;
					end
					else if (state_timer >= toff_ticks - `EDM_DEAD_TIME)
					begin
						mosfet_buck1 <= GATE_OFF; // clear before res1 goes high
						mosfet_buck2 <= GATE_OFF;
						mosfet_res1 <= GATE_OFF;
						mosfet_res2 <= GATE_OFF;
						mosfet_deion <= 1'b0;
					end
					else
					begin
						mosfet_buck1 <= GATE_LOW; // interpulse, lower devices on
						mosfet_buck2 <= GATE_LOW;
						mosfet_res1 <= GATE_LOW;
						mosfet_res2 <= GATE_LOW;
						mosfet_deion <= 1'b1;
					end
				end
				S_WAIT_BREAKDOWN:
				begin
					mosfet_buck1 <= GATE_OFF;
					mosfet_buck2 <= GATE_OFF;
					mosfet_res1 <= GATE_HIGH; // open-circuit voltage on the gap
					mosfet_res2 <= GATE_OFF;
					mosfet_deion <= 1'b0;
				end
				S_BUCK_INTERLEAVE:
				begin
					mosfet_buck1 <= buck1_code;
					mosfet_buck2 <= buck2_code;
				end
				S_RES_DISCHARGE:
					mosfet_res1 <= GATE_HIGH; // discharge through the resistor
				default:
				begin
					mosfet_buck1 <= GATE_OFF;
					mosfet_buck2 <= GATE_OFF;
					mosfet_res1 <= GATE_OFF;
					mosfet_res2 <= GATE_OFF;
					mosfet_deion <= 1'b0;
				end
			endcase
		end
	end

	property legal_code(leg);
		@(posedge clk) disable iff (!rst_n) leg inside {GATE_OFF, GATE_LOW, GATE_HIGH};
	endproperty

	// a leg always passes through off between its two devices
	property dead_time_kept(leg);
		@(posedge clk) disable iff (!rst_n)
			(leg == GATE_LOW |=> leg != GATE_HIGH) and (leg == GATE_HIGH |=> leg != GATE_LOW);
	endproperty

	buck1_legal: assert property (legal_code(mosfet_buck1));
	buck2_legal: assert property (legal_code(mosfet_buck2));
	res1_legal: assert property (legal_code(mosfet_res1));
	res2_legal: assert property (legal_code(mosfet_res2));
	buck1_dead: assert property (dead_time_kept(mosfet_buck1));
	buck2_dead: assert property (dead_time_kept(mosfet_buck2));

endmodule

// ==== logic/pulse_top.sv ====
`timescale 1ns/1ps
`include "edm_settings.svh"

module pulse_top
	import edm_state_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic machine_on,
	input logic [`EDM_SAMPLE_W-1:0] waveform,
	input logic [`EDM_SAMPLE_W-1:0] ton_us,
	input logic [`EDM_SAMPLE_W-1:0] toff_us,
	input logic signed [`EDM_SAMPLE_W-1:0] sample_current,
	input logic signed [`EDM_SAMPLE_W-1:0] sample_voltage,
	output gate_e mosfet_buck1,
	output gate_e mosfet_buck2,
	output gate_e mosfet_res1,
	output gate_e mosfet_res2,
	output logic mosfet_deion,
	output logic is_operation,
	output logic is_breakdown
);

	seq_state_e state;
	logic [`EDM_TIMER_W-1:0] state_timer;
	logic [`EDM_TIMER_W-1:0] toff_ticks; // deion end for the driver
	logic buck_active;
	logic wait_active;
	gate_e buck1_code;
	gate_e buck2_code;

	pulse_sequencer u_seq (.clk, .rst_n, .machine_on, .waveform, .ton_us, .toff_us,
		.sample_current, .is_breakdown, .state, .state_timer, .toff_ticks, .buck_active,
		.wait_active, .is_operation);

	breakdown_detector u_bd (.clk, .rst_n, .wait_active, .sample_voltage, .sample_current,
		.is_breakdown);

	buck_phase_timer u_buck (.clk, .rst_n, .buck_active, .buck1_code, .buck2_code);

	mosfet_driver u_drv (.clk, .rst_n, .state, .state_timer, .toff_ticks, .buck1_code,
		.buck2_code, .mosfet_buck1, .mosfet_buck2, .mosfet_res1, .mosfet_res2, .mosfet_deion);

endmodule

// ==== test/tb_pulse_top.sv ====
`timescale 1ns/1ps
`include "edm_settings.svh"

module tb_pulse_top
	import edm_state_pkg::*, edm_wave_pkg::*;
;

	localparam int N_ROWS = 3;

	logic clk;
	logic rst_n;
	logic machine_on;
	logic [`EDM_SAMPLE_W-1:0] waveform;
	logic [`EDM_SAMPLE_W-1:0] ton_us;
	logic [`EDM_SAMPLE_W-1:0] toff_us;
	logic signed [`EDM_SAMPLE_W-1:0] sample_current;
	logic signed [`EDM_SAMPLE_W-1:0] sample_voltage;
	gate_e mosfet_buck1;
	gate_e mosfet_buck2;
	gate_e mosfet_res1;
	gate_e mosfet_res2;
	logic mosfet_deion;
	logic is_operation;
	logic is_breakdown;

	// case table, one column per array
	string row_name [N_ROWS];
	logic [15:0] row_wave [N_ROWS];
	logic [`EDM_SAMPLE_W-1:0] row_ton [N_ROWS];
	logic [`EDM_SAMPLE_W-1:0] row_toff [N_ROWS];
	bit row_bd [N_ROWS];
	discharge_e row_kind [N_ROWS]; // DIS_NONE means wait timeout
	int row_high_w [N_ROWS]; // first buck HIGH width, or res1 HIGH width

	integer seed = 32'h9393_59f2;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	bit bd_apply = 0; // collapsed gap samples instead of noise
	int cur_force = -1; // fixed current, -1 for noise

	pulse_top u_dut (.clk, .rst_n, .machine_on, .waveform, .ton_us, .toff_us,
		.sample_current, .sample_voltage, .mosfet_buck1, .mosfet_buck2, .mosfet_res1,
		.mosfet_res2, .mosfet_deion, .is_operation, .is_breakdown);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("error: timeout, DUT did not reach the expected output in time");
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input int expected, input int actual,
		input int tol);
		int diff;
		diff = expected - actual;
		if (diff > tol || diff < -tol)
		begin
			$display("[FAIL] %s expected %0d (+-%0d) actual %0d", name, expected, tol, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// one clock edge, then drive the gap samples for the next cycle
	task automatic step();
		@(posedge clk);
		if (bd_apply)
		begin
			sample_voltage <= 20;
			sample_current <= 30;
		end
		else
		begin
			sample_voltage <= 61 + ({$random(seed)} % 40); // open gap, well above threshold
			sample_current <= (cur_force >= 0) ? cur_force : ({$random(seed)} % 21);
		end
	endtask

	task automatic wait_deion_rise();
		logic prev;
		bit seen;
		prev = mosfet_deion;
		seen = 0;
		while (!seen)
		begin
			step();
			seen = mosfet_deion && !prev;
			prev = mosfet_deion;
		end
	endtask

	// measures HIGH runs of one buck leg, checks each width as it closes
	task automatic track_run(input string leg, input int high_w, input gate_e code,
		inout int len, inout int idx);
		int exp_w;
		if (code == GATE_HIGH)
			len = len + 1;
		else if (len > 0)
		begin
			exp_w = (idx < `EDM_RISE_CYCLES) ? high_w : `EDM_CHARGE_STAND;
			check_value(leg, exp_w, len, 0);
			idx = idx + 1;
			len = 0;
		end
	endtask

	task automatic apply_row(input int r);
		waveform <= row_wave[r];
		ton_us <= row_ton[r];
		toff_us <= row_toff[r];
	endtask

	task automatic run_row(input int r);
		int width;
		int bd_wait;
		int len1, len2, idx1, idx2;
		width = 0;
		bd_wait = 0;
		len1 = 0;
		len2 = 0;
		idx1 = 0;
		idx2 = 0;
		// deion interval, lower devices on
		while (mosfet_deion)
		begin
			width++;
			check_value({row_name[r], " buck1 deion"}, GATE_LOW, mosfet_buck1, 0);
			check_value({row_name[r], " buck2 deion"}, GATE_LOW, mosfet_buck2, 0);
			check_value({row_name[r], " res2 deion"}, GATE_LOW, mosfet_res2, 0);
			step();
		end
		check_value({row_name[r], " deion width"}, row_toff[r] * `EDM_TICKS_PER_US
			- 2 * `EDM_DEAD_TIME, width, 2);
		while (mosfet_res1 != GATE_HIGH)
			step(); // wait phase starts
		width = 0;
		if (row_bd[r])
		begin
			bd_apply = 1;
			while (!is_breakdown)
			begin
				step();
				bd_wait++;
			end
			// apply edge, qualify ticks, read edge
			check_value({row_name[r], " breakdown delay"}, `EDM_BD_TICKS + 2, bd_wait, 0);
			step();
		end
		while (mosfet_res1 == GATE_HIGH)
		begin
			width++;
			check_value({row_name[r], " res2 off"}, GATE_OFF, mosfet_res2, 0);
			if (row_kind[r] == DIS_BUCK)
			begin
				track_run({row_name[r], " buck1 run"}, row_high_w[r], mosfet_buck1, len1, idx1);
				track_run({row_name[r], " buck2 run"}, row_high_w[r], mosfet_buck2, len2, idx2);
			end
			else
			begin
				check_value({row_name[r], " buck1 off"}, GATE_OFF, mosfet_buck1, 0);
				check_value({row_name[r], " buck2 off"}, GATE_OFF, mosfet_buck2, 0);
			end
			step();
		end
		bd_apply = 0;
		if (row_kind[r] == DIS_NONE)
			check_value({row_name[r], " wait length"}, `EDM_WAIT_MAX + 2, width, 2);
		else if (row_kind[r] == DIS_RES)
			check_value({row_name[r], " res1 length"}, row_high_w[r], width, 3);
		else
			check_value({row_name[r], " ton length"}, row_ton[r] * `EDM_TICKS_PER_US, width, 3);
		if (row_kind[r] == DIS_BUCK)
		begin
			check_value({row_name[r], " buck1 runs"}, row_ton[r] * `EDM_TICKS_PER_US
				/ `EDM_BUCK_PERIOD, idx1, 0);
			check_value({row_name[r], " buck2 runs"}, row_ton[r] * `EDM_TICKS_PER_US
				/ `EDM_BUCK_PERIOD, idx2, 0);
		end
		wait_deion_rise(); // next toff begins
	endtask

	initial
	begin
		row_name[0] = "buck_bd";
		row_wave[0] = WAVE_BUCK_OPEN;
		row_ton[0] = 20; // five buck periods
		row_toff[0] = 5;
		row_bd[0] = 1;
		row_kind[0] = DIS_BUCK;
		row_high_w[0] = `EDM_CHARGE_RISE;
		row_name[1] = "res_bd";
		row_wave[1] = WAVE_RES;
		row_ton[1] = 3;
		row_toff[1] = 4;
		row_bd[1] = 1;
		row_kind[1] = DIS_RES;
		row_high_w[1] = 300;
		row_name[2] = "no_bd";
		row_wave[2] = WAVE_BUCK_OPEN;
		row_ton[2] = 2;
		row_toff[2] = 3;
		row_bd[2] = 0;
		row_kind[2] = DIS_NONE;
		row_high_w[2] = 0;

		cycle_limit = 16 + 100; // reset plus the operation checks
		for (int r = 0; r < N_ROWS; r++)
			cycle_limit += (row_ton[r] + row_toff[r]) * 100 + `EDM_WAIT_MAX + 500;

		rst_n = 1'b0;
		machine_on = 1'b0;
		waveform = row_wave[0];
		ton_us = row_ton[0];
		toff_us = row_toff[0];
		sample_current = '0;
		sample_voltage = 16'sd80;

		repeat (16) step();
		check_value("reset buck1", GATE_OFF, mosfet_buck1, 0);
		check_value("reset buck2", GATE_OFF, mosfet_buck2, 0);
		check_value("reset res1", GATE_OFF, mosfet_res1, 0);
		check_value("reset res2", GATE_OFF, mosfet_res2, 0);
		check_value("reset deion", 0, mosfet_deion, 0);
		check_value("reset operation", 0, is_operation, 0);
		check_value("reset breakdown", 0, is_breakdown, 0);
		rst_n <= 1'b1;
		machine_on <= 1'b1;

		wait_deion_rise(); // first toff after reset
		for (int r = 0; r < N_ROWS; r++)
		begin
			run_row(r);
			if (r + 1 < N_ROWS)
				apply_row(r + 1);
		end

		// overcurrent gating
		machine_on <= 1'b0;
		repeat (3) step();
		check_value("machine off", 0, is_operation, 0);
		cur_force = 30;
		sample_current <= 30; // total 60, under the limit
		machine_on <= 1'b1;
		repeat (3) step();
		check_value("operation on", 1, is_operation, 0);
		cur_force = 40;
		sample_current <= 40; // total 80, overcurrent
		repeat (3) step();
		check_value("overcurrent off", 0, is_operation, 0);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+logic
logic/edm_state_pkg.sv
logic/edm_wave_pkg.sv
logic/pulse_sequencer.sv
logic/breakdown_detector.sv
logic/buck_phase_timer.sv
logic/mosfet_driver.sv
logic/pulse_top.sv
test/tb_pulse_top.sv

// ==== Bender.yml ====
package:
  name: edm_pulse_gen

export_include_dirs:
  - logic

sources:
  - logic/edm_state_pkg.sv
  - logic/edm_wave_pkg.sv
  - logic/pulse_sequencer.sv
  - logic/breakdown_detector.sv
  - logic/buck_phase_timer.sv
  - logic/mosfet_driver.sv
  - logic/pulse_top.sv
  - target: test
    files:
      - test/tb_pulse_top.sv
